// ==== source/fpu_in.sv ====
// top of the fpu request input, chains capture, predecode, queue and dispatch between crossbar and pipes
`default_nettype none

module fpu_in import fpu_in_pkg::*; (
	input  wire          rclk,	// global clock
	input  wire          arst_n,	// async reset, active low
	input  wire          pcx_data_rdy,	// crossbar beat strobe
	input  wire  [123:0] pcx_data,	// crossbar beat
	input  wire          a1stg_step,	// pipe load strobes
	input  wire          m1stg_step,
	input  wire          d1stg_step,
	input  wire          add_pipe_active,	// pipe busy indications
	input  wire          mul_pipe_active,
	input  wire          div_pipe_active,
	output logic         inq_add,	// pipe requests
	output logic         inq_mul,
	output logic         inq_div,
	output logic [4:0]   inq_id,
	output logic [1:0]   inq_rnd_mode,
	output logic [1:0]   inq_fcc,
	output logic [7:0]   inq_op,
	output logic [63:0]  inq_in1,
	output logic [63:0]  inq_in2,
	output fp_opflags_t  inq_in1_flags,
	output fp_opflags_t  inq_in2_flags,
	output logic         fadd_clken_l,	// pipe clock enables, active low
	output logic         fmul_clken_l,
	output logic         fdiv_clken_l
);

	//////////////////////////////////////////////////
	// stage to stage wires
	//////////////////////////////////////////////////
	logic        cap_vld, pd_vld, head_vld, head_pop, inq_full;
	logic [4:0]  cap_id, pd_id, head_id;
	logic [1:0]  cap_rnd, pd_rnd, head_rnd;
	logic [1:0]  cap_fcc, pd_fcc, head_fcc;
	logic [7:0]  cap_op, pd_op, head_op;
	logic [63:0] cap_src1, pd_src1, head_src1;
	logic [63:0] cap_src2, pd_src2, head_src2;
	fp_pipe_e    pd_pipe, head_pipe;
	fp_opflags_t pd_flags1, pd_flags2, head_flags1, head_flags2;

	fpu_in_capture u_capture (.rclk, .arst_n, .pcx_data_rdy, .pcx_data,
		.cap_vld, .cap_id, .cap_rnd, .cap_fcc, .cap_op, .cap_src1, .cap_src2);

	fpu_in_predecode u_predecode (.rclk, .arst_n,
		.cap_vld, .cap_id, .cap_rnd, .cap_fcc, .cap_op, .cap_src1, .cap_src2,
		.pd_vld, .pd_id, .pd_rnd, .pd_fcc, .pd_op, .pd_src1, .pd_src2,
		.pd_pipe, .pd_flags1, .pd_flags2);

	fpu_in_queue u_queue (.rclk, .arst_n,
		.pd_vld, .pd_id, .pd_rnd, .pd_fcc, .pd_op, .pd_src1, .pd_src2,
		.pd_pipe, .pd_flags1, .pd_flags2, .head_pop,
		.head_vld, .head_id, .head_rnd, .head_fcc, .head_op, .head_src1, .head_src2,
		.head_pipe, .head_flags1, .head_flags2,
		.full (inq_full));	// read only by the bound checks

	fpu_in_dispatch u_dispatch (.head_vld, .head_pipe, .head_id, .head_rnd, .head_fcc,
		.head_op, .head_src1, .head_src2, .head_flags1, .head_flags2,
		.a1stg_step, .m1stg_step, .d1stg_step,
		.add_pipe_active, .mul_pipe_active, .div_pipe_active,
		.head_pop, .inq_add, .inq_mul, .inq_div,
		.inq_id, .inq_rnd_mode, .inq_fcc, .inq_op, .inq_in1, .inq_in2,
		.inq_in1_flags, .inq_in2_flags,
		.fadd_clken_l, .fmul_clken_l, .fdiv_clken_l);

endmodule

`default_nettype wire

// ==== source/fpu_in_capture.sv ====
// stage 1 of the fpu request input, pairs crossbar beats A and B into one registered request
`default_nettype none
`include "fpu_in_config.svh"

module fpu_in_capture (
	input  wire          rclk,	// global clock
	input  wire          arst_n,	// async reset, active low
	input  wire          pcx_data_rdy,	// beat strobe from the crossbar
	input  wire  [123:0] pcx_data,	// beat payload
	output logic         cap_vld,	// one-cycle pulse per assembled request
	output logic [4:0]   cap_id,	// request id
	output logic [1:0]   cap_rnd,	// rounding mode
	output logic [1:0]   cap_fcc,	// condition code select
	output logic [7:0]   cap_op,	// opcode
	output logic [63:0]  cap_src1,	// operand 1 from beat A
	output logic [63:0]  cap_src2	// operand 2 from beat B, zero if single source
);

	logic        wait_b;	// 0 waiting for beat A, 1 holding A and waiting for B
	logic [4:0]  beat_type;	// type field of the current beat
	logic        beat_a;	// accepted beat A
	logic        beat_b;	// accepted beat B
	logic [4:0]  a_id;	// beat A fields held until B
	logic [1:0]  a_rnd;
	logic [1:0]  a_fcc;
	logic [7:0]  a_op;
	logic [63:0] a_src1;

	assign beat_type = pcx_data[`FPU_PKT_TYPE_HI:`FPU_PKT_TYPE_LO];

	// beats of the wrong type for the current state fall through unused
	assign beat_a = pcx_data_rdy & pcx_data[`FPU_PKT_VLD] &
			(beat_type == `FPU_PKT_TYPE_A) & ~wait_b;
	assign beat_b = pcx_data_rdy & (beat_type == `FPU_PKT_TYPE_B) & wait_b;	// valid bit may be low

	//////////////////////////////////////////////////
	// beat pairing state
	//////////////////////////////////////////////////
	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			wait_b  <= 1'b0;
			cap_vld <= 1'b0;
		end else begin
			cap_vld <= beat_b;	// pulse after the edge that took B
			if (beat_a)
				wait_b <= 1'b1;
			else if (beat_b)
				wait_b <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// payload registers
	//////////////////////////////////////////////////
	always_ff @(posedge rclk) begin
		if (beat_a) begin
			a_id   <= pcx_data[`FPU_PKT_ID_HI -: 5];
			a_rnd  <= pcx_data[`FPU_PKT_RND_HI -: 2];
			a_fcc  <= pcx_data[`FPU_PKT_FCC_HI -: 2];
			a_op   <= pcx_data[`FPU_PKT_OP_HI -: 8];
			a_src1 <= pcx_data[`FPU_PKT_DATA_HI:0];
		end
	end

	always_ff @(posedge rclk) begin
		if (beat_b) begin
			cap_id   <= a_id;
			cap_rnd  <= a_rnd;
			cap_fcc  <= a_fcc;
			cap_op   <= a_op;
			cap_src1 <= a_src1;
			// invalid B beat means single source, operand 2 reads as zero
			cap_src2 <= pcx_data[`FPU_PKT_VLD] ? pcx_data[`FPU_PKT_DATA_HI:0] : 64'h0;
		end
	end

endmodule

`default_nettype wire

// ==== source/fpu_in_config.svh ====
// queue sizing and crossbar packet layout for the fpu request input, included by the RTL
`ifndef FPU_IN_CONFIG_SVH
`define FPU_IN_CONFIG_SVH

//////////////////////////////////////////////////
// input queue sizing
//////////////////////////////////////////////////
`define FPU_INQ_DEPTH     16	// request entries
`define FPU_INQ_AW        4	// pointer width, depth is 2**AW

//////////////////////////////////////////////////
// 124-bit crossbar packet fields
//////////////////////////////////////////////////
`define FPU_PKT_VLD       123	// beat valid
`define FPU_PKT_TYPE_HI   122	// beat type, 5 bits
`define FPU_PKT_TYPE_LO   118
`define FPU_PKT_ID_HI     116	// request id, 5 bits
`define FPU_PKT_OP_HI     79	// opcode, 8 bits
`define FPU_PKT_RND_HI    67	// rounding mode, 2 bits
`define FPU_PKT_FCC_HI    65	// condition code select, 2 bits
`define FPU_PKT_DATA_HI   63	// operand, 64 bits down to 0

`define FPU_PKT_TYPE_A    5'h0a	// first beat, operand 1
`define FPU_PKT_TYPE_B    5'h0b	// second beat, operand 2

`endif

// ==== source/fpu_in_dispatch.sv ====
// stage 4 of the fpu request input, steers the queue head to one pipe and drives pipe clock enables
`default_nettype none

module fpu_in_dispatch import fpu_in_pkg::*; (
	input  wire          head_vld,	// queue holds a request
	input  fp_pipe_e     head_pipe,	// its target pipe
	input  wire  [4:0]   head_id,
	input  wire  [1:0]   head_rnd,
	input  wire  [1:0]   head_fcc,
	input  wire  [7:0]   head_op,
	input  wire  [63:0]  head_src1,
	input  wire  [63:0]  head_src2,
	input  fp_opflags_t  head_flags1,
	input  fp_opflags_t  head_flags2,
	input  wire          a1stg_step,	// add pipe takes its request
	input  wire          m1stg_step,	// mul pipe takes its request
	input  wire          d1stg_step,	// div pipe takes its request
	input  wire          add_pipe_active,	// add pipe busy with earlier work
	input  wire          mul_pipe_active,
	input  wire          div_pipe_active,
	output logic         head_pop,	// head consumed this cycle
	output logic         inq_add,	// add pipe request
	output logic         inq_mul,	// mul pipe request
	output logic         inq_div,	// div pipe request
	output logic [4:0]   inq_id,
	output logic [1:0]   inq_rnd_mode,
	output logic [1:0]   inq_fcc,
	output logic [7:0]   inq_op,
	output logic [63:0]  inq_in1,
	output logic [63:0]  inq_in2,
	output fp_opflags_t  inq_in1_flags,
	output fp_opflags_t  inq_in2_flags,
	output logic         fadd_clken_l,	// add pipe clock enable, active low
	output logic         fmul_clken_l,
	output logic         fdiv_clken_l
);

	//////////////////////////////////////////////////
	// request lines, one hot while the head is valid
	//////////////////////////////////////////////////
	assign inq_add = head_vld & (head_pipe == PIPE_ADD);
	assign inq_mul = head_vld & (head_pipe == PIPE_MUL);
	assign inq_div = head_vld & (head_pipe == PIPE_DIV);

	// a step from a pipe with nothing requested is not a pop
	assign head_pop = (inq_add & a1stg_step) |
			(inq_mul & m1stg_step) |
			(inq_div & d1stg_step);

	// fields go out shared, the request line says which pipe owns them
	assign inq_id        = head_id;
	assign inq_rnd_mode  = head_rnd;
	assign inq_fcc       = head_fcc;
	assign inq_op        = head_op;
	assign inq_in1       = head_src1;
	assign inq_in2       = head_src2;
	assign inq_in1_flags = head_flags1;
	assign inq_in2_flags = head_flags2;

	// clock runs while a pipe has work waiting or in flight
	assign fadd_clken_l = ~(inq_add | add_pipe_active);
	assign fmul_clken_l = ~(inq_mul | mul_pipe_active);
	assign fdiv_clken_l = ~(inq_div | div_pipe_active);

endmodule

`default_nettype wire

// ==== source/fpu_in_pkg.sv ====
// shared operand, pipe select and flag types for the fpu request input, imported by its stages
`default_nettype none

package fpu_in_pkg;

	//////////////////////////////////////////////////
	// one 64-bit operand, read as double or single
	//////////////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic        sign;	// dp sign
			logic [10:0] exp;	// dp biased exponent
			logic [51:0] frac;	// dp fraction
		} dp;
		struct packed {
			logic        sign;	// sp sign, top of the word
			logic [7:0]  exp;	// sp biased exponent
			logic [22:0] frac;	// sp fraction
			logic [31:0] lo;	// unused half, zero from the sender
		} sp;
	} fp_operand_u;

	//////////////////////////////////////////////////
	// target pipe, from opcode bits 3:2
	//////////////////////////////////////////////////
	typedef enum logic [1:0] {
		PIPE_ADD = 2'b00,	// add, sub, convert and compare
		PIPE_MUL = 2'b01,	// multiply
		PIPE_DIV = 2'b10	// divide
	} fp_pipe_e;

	// special-value hints for one operand, computed ahead of the pipes
	// so the first pipe stage does not need the wide compares
	typedef struct packed {
		logic exp_neq_ffs;	// exponent not all ones
		logic exp_eq_0;	// exponent zero, zero or denormal
		logic frac_neq_0;	// fraction nonzero, nan or denormal
	} fp_opflags_t;

endpackage

`default_nettype wire

// ==== source/fpu_in_predecode.sv ====
// stage 2 of the fpu request input, registers the request with pipe select and operand flags
`default_nettype none

module fpu_in_predecode import fpu_in_pkg::*; (
	input  wire          rclk,	// global clock
	input  wire          arst_n,	// async reset, active low
	input  wire          cap_vld,	// request from capture
	input  wire  [4:0]   cap_id,
	input  wire  [1:0]   cap_rnd,
	input  wire  [1:0]   cap_fcc,
	input  wire  [7:0]   cap_op,
	input  wire  [63:0]  cap_src1,
	input  wire  [63:0]  cap_src2,
	output logic         pd_vld,	// request to the queue
	output logic [4:0]   pd_id,
	output logic [1:0]   pd_rnd,
	output logic [1:0]   pd_fcc,
	output logic [7:0]   pd_op,
	output logic [63:0]  pd_src1,
	output logic [63:0]  pd_src2,
	output fp_pipe_e     pd_pipe,	// target pipe
	output fp_opflags_t  pd_flags1,	// operand 1 hints
	output fp_opflags_t  pd_flags2	// operand 2 hints
);

	fp_pipe_e    pipe_d;	// decoded target pipe
	fp_opflags_t flags1_d;	// unregistered operand hints
	fp_opflags_t flags2_d;

	// same checks on either view, only the field widths differ
	function automatic fp_opflags_t op_flags(input fp_operand_u opnd, input logic dbl);
		fp_opflags_t f;
		if (dbl) begin
			f.exp_neq_ffs = ~&opnd.dp.exp;
			f.exp_eq_0    = ~|opnd.dp.exp;
			f.frac_neq_0  = |opnd.dp.frac;
		end else begin
			f.exp_neq_ffs = ~&opnd.sp.exp;
			f.exp_eq_0    = ~|opnd.sp.exp;
			f.frac_neq_0  = |opnd.sp.frac;
		end
		return f;
	endfunction

	assign flags1_d = op_flags(cap_src1, cap_op[1]);	// op[1] set for double
	assign flags2_d = op_flags(cap_src2, cap_op[1]);

	always_comb begin
		case (cap_op[3:2])
			2'b01:   pipe_d = PIPE_MUL;
			2'b10:   pipe_d = PIPE_DIV;
			default: pipe_d = PIPE_ADD;	// add and compare
		endcase
	end

	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n)
			pd_vld <= 1'b0;
		else
			pd_vld <= cap_vld;
	end

	always_ff @(posedge rclk) begin
		if (cap_vld) begin
			pd_id     <= cap_id;
			pd_rnd    <= cap_rnd;
			pd_fcc    <= cap_fcc;
			pd_op     <= cap_op;
			pd_src1   <= cap_src1;
			pd_src2   <= cap_src2;
			pd_pipe   <= pipe_d;
			pd_flags1 <= flags1_d;
			pd_flags2 <= flags2_d;
		end
	end

endmodule

`default_nettype wire

// ==== source/fpu_in_queue.sv ====
// stage 3 of the fpu request input, in-order request store with a combinational head read
`default_nettype none
`include "fpu_in_config.svh"

module fpu_in_queue import fpu_in_pkg::*; (
	input  wire          rclk,	// global clock
	input  wire          arst_n,	// async reset, active low
	input  wire          pd_vld,	// write strobe from predecode
	input  wire  [4:0]   pd_id,
	input  wire  [1:0]   pd_rnd,
	input  wire  [1:0]   pd_fcc,
	input  wire  [7:0]   pd_op,
	input  wire  [63:0]  pd_src1,
	input  wire  [63:0]  pd_src2,
	input  fp_pipe_e     pd_pipe,
	input  fp_opflags_t  pd_flags1,
	input  fp_opflags_t  pd_flags2,
	input  wire          head_pop,	// head consumed this cycle
	output logic         head_vld,	// queue not empty
	output logic [4:0]   head_id,
	output logic [1:0]   head_rnd,
	output logic [1:0]   head_fcc,
	output logic [7:0]   head_op,
	output logic [63:0]  head_src1,
	output logic [63:0]  head_src2,
	output fp_pipe_e     head_pipe,
	output fp_opflags_t  head_flags1,
	output fp_opflags_t  head_flags2,
	output logic         full	// all entries occupied
);

	localparam int DEPTH = `FPU_INQ_DEPTH;
	localparam int AW    = `FPU_INQ_AW;
	localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);

	//////////////////////////////////////////////////
	// storage, one array per field
	//////////////////////////////////////////////////
	logic [4:0]  mem_id    [DEPTH];
	logic [1:0]  mem_rnd   [DEPTH];
	logic [1:0]  mem_fcc   [DEPTH];
	logic [7:0]  mem_op    [DEPTH];
	logic [63:0] mem_src1  [DEPTH];
	logic [63:0] mem_src2  [DEPTH];
	fp_pipe_e    mem_pipe  [DEPTH];
	fp_opflags_t mem_flags1[DEPTH];
	fp_opflags_t mem_flags2[DEPTH];

	logic [AW-1:0] wr_ptr;	// next free entry
	logic [AW-1:0] rd_ptr;	// oldest entry
	logic [AW:0]   count;	// occupied entries, 0 to DEPTH
	logic          push;
	logic          pop;

	assign pop  = head_pop & head_vld;
	assign push = pd_vld & (~full | pop);	// a pop frees the slot the write lands in
	assign full = (count == (AW+1)'(DEPTH));
	assign head_vld = (count != '0);

	always_ff @(posedge rclk) begin
		if (push) begin
			mem_id[wr_ptr]     <= pd_id;
			mem_rnd[wr_ptr]    <= pd_rnd;
			mem_fcc[wr_ptr]    <= pd_fcc;
			mem_op[wr_ptr]     <= pd_op;
			mem_src1[wr_ptr]   <= pd_src1;
			mem_src2[wr_ptr]   <= pd_src2;
			mem_pipe[wr_ptr]   <= pd_pipe;
			mem_flags1[wr_ptr] <= pd_flags1;
			mem_flags2[wr_ptr] <= pd_flags2;
		end
	end

	//////////////////////////////////////////////////
	// pointers and occupancy
	//////////////////////////////////////////////////
	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	// head read, no register between array and pipes
	assign head_id     = mem_id[rd_ptr];
	assign head_rnd    = mem_rnd[rd_ptr];
	assign head_fcc    = mem_fcc[rd_ptr];
	assign head_op     = mem_op[rd_ptr];
	assign head_src1   = mem_src1[rd_ptr];
	assign head_src2   = mem_src2[rd_ptr];
	assign head_pipe   = mem_pipe[rd_ptr];
	assign head_flags1 = mem_flags1[rd_ptr];
	assign head_flags2 = mem_flags2[rd_ptr];

endmodule

`default_nettype wire

// ==== verif/fpu_in_asserts.sv ====
// protocol and queue checks for the fpu request input, bound onto the top level by the bind below
`default_nettype none

module fpu_in_asserts (
	input wire        rclk,	// global clock
	input wire        arst_n,	// async reset, active low
	input wire        pd_vld,	// queue write strobe
	input wire        inq_full,	// queue occupancy at depth
	input wire        head_pop,	// head consumed
	input wire        inq_add,	// pipe requests
	input wire        inq_mul,
	input wire        inq_div,
	input wire        a1stg_step,	// pipe load strobes
	input wire        m1stg_step,
	input wire        d1stg_step,
	input wire [4:0]  inq_id,	// head fields that must hold
	input wire [7:0]  inq_op,
	input wire [63:0] inq_in1,
	input wire [63:0] inq_in2
);

	int fail_cnt = 0;	// failed checks, summed into the testbench error count

	//////////////////////////////////////////////////
	// occupancy, sender keeps at most 16 outstanding
	//////////////////////////////////////////////////
	no_write_when_full: assert property (@(posedge rclk) disable iff (!arst_n)
		pd_vld && inq_full |-> head_pop) else begin
		$error("queue written while full");
		fail_cnt++;
	end

	one_request: assert property (@(posedge rclk) disable iff (!arst_n)
		$onehot0({inq_add, inq_mul, inq_div})) else begin
		$error("more than one request line high");
		fail_cnt++;
	end

	//////////////////////////////////////////////////
	// a request holds until its pipe steps
	//////////////////////////////////////////////////
	add_hold: assert property (@(posedge rclk) disable iff (!arst_n)
		inq_add && !a1stg_step |=> inq_add && $stable({inq_id, inq_op, inq_in1, inq_in2}))
		else begin
		$error("add request dropped or changed without a1stg_step");
		fail_cnt++;
	end
	mul_hold: assert property (@(posedge rclk) disable iff (!arst_n)
		inq_mul && !m1stg_step |=> inq_mul && $stable({inq_id, inq_op, inq_in1, inq_in2}))
		else begin
		$error("mul request dropped or changed without m1stg_step");
		fail_cnt++;
	end
	div_hold: assert property (@(posedge rclk) disable iff (!arst_n)
		inq_div && !d1stg_step |=> inq_div && $stable({inq_id, inq_op, inq_in1, inq_in2}))
		else begin
		$error("div request dropped or changed without d1stg_step");
		fail_cnt++;
	end

endmodule

bind fpu_in fpu_in_asserts u_asserts (.rclk, .arst_n, .pd_vld, .inq_full, .head_pop,
	.inq_add, .inq_mul, .inq_div, .a1stg_step, .m1stg_step, .d1stg_step,
	.inq_id, .inq_op, .inq_in1, .inq_in2);

`default_nettype wire

// ==== verif/fpu_in_tb.sv ====
// directed testbench for the fpu request input, compiled from verilog.f with fpu_in_tb as top
`default_nettype none
`include "fpu_in_config.svh"

module fpu_in_tb import fpu_in_pkg::*; ();

	localparam int MAX_CYCLES = 2000;	// well beyond the length of all tests
	localparam int WAIT_MAX   = 20;	// cycles allowed for a request line to rise

	typedef struct packed {
		logic [4:0]  id;
		logic [1:0]  rnd;
		logic [1:0]  fcc;
		logic [7:0]  op;
		logic [63:0] src1;
		logic [63:0] src2;
		fp_pipe_e    pipe;
		fp_opflags_t f1;
		fp_opflags_t f2;
	} exp_req_t;

	logic         rclk, arst_n, pcx_data_rdy;
	logic [123:0] pcx_data;
	logic         a1stg_step, m1stg_step, d1stg_step;
	logic         add_pipe_active, mul_pipe_active, div_pipe_active;
	logic         inq_add, inq_mul, inq_div;
	logic [4:0]   inq_id;
	logic [1:0]   inq_rnd_mode, inq_fcc;
	logic [7:0]   inq_op;
	logic [63:0]  inq_in1, inq_in2;
	fp_opflags_t  inq_in1_flags, inq_in2_flags;
	logic         fadd_clken_l, fmul_clken_l, fdiv_clken_l;

	exp_req_t    sb[$];	// expected requests, oldest first
	logic [31:0] lfsr = 32'hd84b_946c;
	int          errors = 0, checked = 0, tests = 0, test_mark = 0, cycle_cnt = 0;

	fpu_in DUT (.*);

	initial begin
		rclk = 1'b0;
		forever #50 rclk = ~rclk;
	end

	initial begin	// watchdog
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge rclk);
			cycle_cnt++;
		end
		$display("run stopped by timeout after %0d cycles", cycle_cnt);
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// stimulus helpers and reference model
	//////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);	// taps 32 22 2 1
	endfunction

	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		repeat (n) begin
			lfsr = lfsr_step(lfsr);
			v = {v[62:0], lfsr[0]};	// one step per bit
		end
	endtask

	function automatic fp_opflags_t model_flags(input logic [63:0] w, input logic dbl);
		fp_opflags_t r;
		if (dbl) begin	// sign, 11-bit exp, 52-bit frac
			r.exp_neq_ffs = (w[62:52] != 11'h7ff);
			r.exp_eq_0    = (w[62:52] == 11'h0);
			r.frac_neq_0  = (w[51:0] != 52'h0);
		end else begin	// sign, 8-bit exp, 23-bit frac in the upper half
			r.exp_neq_ffs = (w[62:55] != 8'hff);
			r.exp_eq_0    = (w[62:55] == 8'h0);
			r.frac_neq_0  = (w[54:32] != 23'h0);
		end
		return r;
	endfunction

	function automatic logic [63:0] special_val(input int k, input logic dbl);
		case (k)
			0:       return 64'h0;	// zero
			1:       return dbl ? 64'h0000_0000_0000_0001 : 64'h0000_0001_0000_0000;	// denormal
			2:       return dbl ? 64'h7ff0_0000_0000_0000 : 64'h7f80_0000_0000_0000;	// infinity
			3:       return dbl ? 64'h7ff8_0000_0000_0000 : 64'h7fc0_0000_0000_0000;	// quiet nan
			default: return dbl ? 64'hbff8_0000_0000_0000 : 64'hbfc0_0000_0000_0000;	// -1.5
		endcase
	endfunction

	function automatic logic [123:0] make_beat(input logic vld, input logic [4:0] typ,
			input logic [4:0] id, input logic [7:0] op, input logic [1:0] rnd,
			input logic [1:0] fcc, input logic [63:0] data);
		logic [123:0] p;
		p = '0;
		p[`FPU_PKT_VLD] = vld;
		p[`FPU_PKT_TYPE_HI:`FPU_PKT_TYPE_LO] = typ;
		p[`FPU_PKT_ID_HI -: 5] = id;
		p[`FPU_PKT_OP_HI -: 8] = op;
		p[`FPU_PKT_RND_HI -: 2] = rnd;
		p[`FPU_PKT_FCC_HI -: 2] = fcc;
		p[`FPU_PKT_DATA_HI:0] = data;
		return p;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Mismatch at time %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("%s test done, %0d errors", name, errors - test_mark);
		test_mark = errors;
	endtask

	// beat A, optional idle cycles, beat B; returns just after the edge that takes B
	task automatic send_req(input logic [4:0] id, input logic [1:0] rnd, input logic [1:0] fcc,
			input logic [7:0] op, input logic [63:0] src1, input logic [63:0] src2,
			input logic two_src, input int idle);
		exp_req_t e;
		e.id   = id;
		e.rnd  = rnd;
		e.fcc  = fcc;
		e.op   = op;
		e.src1 = src1;
		e.src2 = two_src ? src2 : 64'h0;	// single source, operand 2 zero
		e.pipe = (op[3:2] == 2'b01) ? PIPE_MUL : (op[3:2] == 2'b10) ? PIPE_DIV : PIPE_ADD;
		e.f1   = model_flags(src1, op[1]);	// op[1] picks double
		e.f2   = model_flags(e.src2, op[1]);
		sb.push_back(e);
		@(posedge rclk);
		pcx_data_rdy <= 1'b1;
		pcx_data     <= make_beat(1'b1, `FPU_PKT_TYPE_A, id, op, rnd, fcc, src1);
		repeat (idle) begin
			@(posedge rclk);
			pcx_data_rdy <= 1'b0;
		end
		@(posedge rclk);
		pcx_data_rdy <= 1'b1;
		pcx_data     <= make_beat(two_src, `FPU_PKT_TYPE_B, 5'h0, 8'h0, 2'h0, 2'h0, src2);
		@(posedge rclk);
		pcx_data_rdy <= 1'b0;
		pcx_data     <= '0;
	endtask

	task automatic check_head(input exp_req_t e);
		checked++;
		assert ({inq_add, inq_mul, inq_div} ==
				{e.pipe == PIPE_ADD, e.pipe == PIPE_MUL, e.pipe == PIPE_DIV})
			else report_mismatch($sformatf("request lines %b%b%b for pipe %0d",
				inq_add, inq_mul, inq_div, e.pipe));
		assert ({inq_id, inq_rnd_mode, inq_fcc, inq_op} == {e.id, e.rnd, e.fcc, e.op})
			else report_mismatch($sformatf("id %h rnd %h fcc %h op %h, expected %h %h %h %h",
				inq_id, inq_rnd_mode, inq_fcc, inq_op, e.id, e.rnd, e.fcc, e.op));
		assert (inq_in1 == e.src1 && inq_in2 == e.src2)
			else report_mismatch($sformatf("operands %h %h, expected %h %h",
				inq_in1, inq_in2, e.src1, e.src2));
		assert (inq_in1_flags == e.f1 && inq_in2_flags == e.f2)
			else report_mismatch($sformatf("flags %b %b, expected %b %b",
				inq_in1_flags, inq_in2_flags, e.f1, e.f2));
	endtask

	task automatic consume(input fp_pipe_e p);
		@(posedge rclk);
		a1stg_step <= (p == PIPE_ADD);	// step only the pipe that is asked
		m1stg_step <= (p == PIPE_MUL);
		d1stg_step <= (p == PIPE_DIV);
		@(posedge rclk);
		{a1stg_step, m1stg_step, d1stg_step} <= 3'b000;
	endtask

	task automatic drain(input int n);
		int waited;
		repeat (n) begin
			waited = 0;
			@(negedge rclk);
			while (!(inq_add | inq_mul | inq_div) && waited < WAIT_MAX) begin
				@(negedge rclk);
				waited++;
			end
			assert (inq_add | inq_mul | inq_div) else begin
				$display("no request line rose within %0d cycles", WAIT_MAX);
				errors++;
			end
			check_head(sb[0]);
			consume(sb[0].pipe);
			void'(sb.pop_front());
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic reset_state_test;
		@(negedge rclk);
		assert ({inq_add, inq_mul, inq_div} == 3'b000)
			else report_mismatch("request line high after reset");
		assert ({fadd_clken_l, fmul_clken_l, fdiv_clken_l} == 3'b111)
			else report_mismatch("clock enable active after reset");
		finish_test("reset_state");
	endtask

	task automatic single_add_test;
		send_req(5'h03, 2'b10, 2'b01, 8'h42, 64'h4009_21fb_5444_2d18,
			64'hc000_0000_0000_0000, 1'b1, 0);	// double add
		repeat (2) begin
			@(negedge rclk);
			assert (!inq_add) else report_mismatch("inq_add before the third edge after beat B");
		end
		@(negedge rclk);
		check_head(sb[0]);
		assert (!fadd_clken_l && fmul_clken_l && fdiv_clken_l)
			else report_mismatch("clock enables wrong while add is requested");
		@(negedge rclk);
		check_head(sb[0]);	// held with no step
		consume(PIPE_ADD);
		void'(sb.pop_front());
		@(negedge rclk);
		assert (!inq_add && fadd_clken_l)
			else report_mismatch("add request or fadd_clken_l still active after a1stg_step");
		finish_test("single_add");
	endtask

	task automatic flags_test;
		int d;
		int k;
		for (d = 0; d < 2; d++)
			for (k = 0; k < 5; k++)
				send_req(5'(d * 8 + k), 2'b00, 2'b00, d ? 8'h46 : 8'h45,
					special_val(k, d[0]), special_val((k + 2) % 5, d[0]), 1'b1, 0);
		drain(10);
		finish_test("special_flags");
	endtask

	task automatic single_source_div_test;
		logic [63:0] junk;
		take_bits(64, junk);	// beat B payload that must not appear
		send_req(5'h11, 2'b11, 2'b10, 8'h4a, 64'h4024_0000_0000_0000, junk, 1'b0, 3);
		send_req(5'h12, 2'b01, 2'b00, 8'h49, 64'h4120_0000_0000_0000, junk, 1'b0, 0);
		drain(2);
		finish_test("single_source_div");
	endtask

	task automatic queue_order_test;
		logic [63:0] sel, dbl, id, misc, a, b;
		repeat (16) begin
			take_bits(2, sel);
			take_bits(1, dbl);
			take_bits(5, id);
			take_bits(4, misc);
			take_bits(64, a);
			take_bits(64, b);
			if (!dbl[0]) begin	// single operands leave the low half zero
				a[31:0] = '0;
				b[31:0] = '0;
			end
			send_req(id[4:0], misc[3:2], misc[1:0], {4'h4, sel[1:0], dbl[0], 1'b0},
				a, b, 1'b1, 0);
		end
		repeat (3) begin
			@(negedge rclk);
			check_head(sb[0]);	// first request holds while steps stay low
		end
		drain(16);
		finish_test("queue_order");
	endtask

	task automatic pipe_active_test;
		int k;
		for (k = 0; k < 3; k++) begin
			@(posedge rclk);
			{add_pipe_active, mul_pipe_active, div_pipe_active} <= 3'b100 >> k;
			@(negedge rclk);
			assert ({fadd_clken_l, fmul_clken_l, fdiv_clken_l} == ~(3'b100 >> k))
				else report_mismatch($sformatf("clock enables %b with active input %0d",
					{fadd_clken_l, fmul_clken_l, fdiv_clken_l}, k));
		end
		@(posedge rclk);
		{add_pipe_active, mul_pipe_active, div_pipe_active} <= 3'b000;
		@(negedge rclk);
		assert ({fadd_clken_l, fmul_clken_l, fdiv_clken_l} == 3'b111)
			else report_mismatch("clock enable stays active with the pipes idle");
		finish_test("pipe_active");
	endtask

	initial begin
		arst_n       = 1'b0;
		pcx_data_rdy = 1'b0;
		pcx_data     = '0;
		{a1stg_step, m1stg_step, d1stg_step} = 3'b000;
		{add_pipe_active, mul_pipe_active, div_pipe_active} = 3'b000;
		repeat (2) @(posedge rclk);
		arst_n <= 1'b1;
		reset_state_test;
		single_add_test;
		flags_test;
		single_source_div_test;
		queue_order_test;
		pipe_active_test;
		@(negedge rclk);
		errors += DUT.u_asserts.fail_cnt;	// bound protocol checks
		$display("%0d tests, %0d request checks, %0d errors", tests, checked, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+source
source/fpu_in_pkg.sv
source/fpu_in_capture.sv
source/fpu_in_predecode.sv
source/fpu_in_queue.sv
source/fpu_in_dispatch.sv
source/fpu_in.sv
verif/fpu_in_asserts.sv
verif/fpu_in_tb.sv
